// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_psram_tester
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qx 'ALL CHECKS PASSED' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== access_if.sv ====
`timescale 1ns/1ps

interface access_if;
	import psram_test_pkg::*;

	// command side, from the sequencer
	logic cmd_wr;
	logic cmd_rd;
	ram_addr_u address;
	logic [data_width-1:0] wdata;

	// completion side, from the port controller
	logic done;
	logic [data_width-1:0] rdata;

	modport seq (output cmd_wr, cmd_rd, address, wdata, input done, rdata);
	modport port (input cmd_wr, cmd_rd, address, wdata, output done, rdata);

endinterface

// ==== march_sequencer.sv ====
`timescale 1ns/1ps

module march_sequencer #(
	parameter int test_pages = 16384,
	parameter int settle_cycles = 54000000
) (
	input logic clk,
	input logic n_reset,
	input logic initial_busy,
	access_if.seq acc,
	report_if.seq rep,
	output logic test_done,
	output logic test_fail
);
	import psram_test_pkg::*;

	logic [3:0] state;
	logic [3:0] rep_next;
	logic phase;
	ram_addr_u addr;
	logic [31:0] settle_count;
	logic [data_width-1:0] expected;
	logic [offset_width-1:0] offset_first;
	logic [offset_width-1:0] offset_last;
	logic [offset_width-1:0] offset_step;
	logic last_page;

	// phase one walks offsets upward, phase two downward
	assign offset_first = phase ? '1 : '0;
	assign offset_last = phase ? '0 : '1;
	assign offset_step = phase ? addr.pg.offset - 1'b1 : addr.pg.offset + 1'b1;
	assign last_page = addr.pg.page == page_width'(test_pages - 1);

	assign expected = addr.pg.offset ^ test_pattern;
	assign acc.address = addr;
	assign acc.wdata = expected;
	assign rep.fail_address = addr;

	// ------------------------------
	// test program
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (!n_reset)
		begin
			state <= seq_boot;
			rep_next <= seq_boot;
			phase <= 1'b0;
			addr <= '0;
			settle_count <= '0;
			acc.cmd_wr <= 1'b0;
			acc.cmd_rd <= 1'b0;
			rep.start <= 1'b0;
			rep.msg <= msg_banner;
			test_done <= 1'b0;
			test_fail <= 1'b0;
		end
		else
		begin
			acc.cmd_wr <= 1'b0;
			acc.cmd_rd <= 1'b0;
			rep.start <= 1'b0;
			case (state)
			seq_boot:
				state <= seq_banner;
			seq_banner:
			begin
				rep.start <= 1'b1;
				rep.msg <= msg_banner;
				rep_next <= seq_init_wait;
				state <= seq_rep_wait;
			end
			seq_init_wait:
				if (!initial_busy)
				begin
					rep.start <= 1'b1;
					rep.msg <= msg_ok;
					settle_count <= '0;
					rep_next <= seq_settle;
					state <= seq_rep_wait;
				end
			seq_settle:
				if (settle_count == 32'(settle_cycles - 1))
				begin
					rep.start <= 1'b1;
					rep.msg <= msg_ram0;
					phase <= 1'b0;
					addr <= '0;
					rep_next <= seq_write;
					state <= seq_rep_wait;
				end
				else
					settle_count <= settle_count + 1'b1;
			// write one whole page
			seq_write:
			begin
				acc.cmd_wr <= 1'b1;
				state <= seq_write_wait;
			end
			seq_write_wait:
				if (acc.done)
				begin
					if (addr.pg.offset == offset_last)
					begin
						addr.pg.offset <= offset_first;
						state <= seq_read;
					end
					else
					begin
						addr.pg.offset <= offset_step;
						state <= seq_write;
					end
				end
			// then verify it in the same direction
			seq_read:
			begin
				acc.cmd_rd <= 1'b1;
				state <= seq_read_wait;
			end
			seq_read_wait:
				if (acc.done)
				begin
					if (acc.rdata != expected)
					begin
						test_fail <= 1'b1;
						rep.start <= 1'b1;
						rep.msg <= msg_ng;
						rep_next <= seq_next_phase;
						state <= seq_rep_wait;
					end
					else if (addr.pg.offset != offset_last)
					begin
						addr.pg.offset <= offset_step;
						state <= seq_read;
					end
					else if (last_page)
					begin
						rep.start <= 1'b1;
						rep.msg <= msg_ok;
						rep_next <= seq_next_phase;
						state <= seq_rep_wait;
					end
					else
					begin
						addr.pg.page <= addr.pg.page + 1'b1;
						addr.pg.offset <= offset_first;
						state <= seq_write;
					end
				end
			seq_rep_wait:
				if (rep.done)
					state <= rep_next;
			seq_next_phase:
				if (!phase)
				begin
					phase <= 1'b1;
					addr.pg.page <= '0;
					addr.pg.offset <= '1;
					state <= seq_write;
				end
				else
				begin
					test_done <= 1'b1;
					state <= seq_done;
				end
			// end of program, levels stay put
			seq_done:
				test_done <= 1'b1;
			default:
				state <= seq_boot;
			endcase
		end
	end

	// failing byte for the NG line
	always_ff @(posedge clk)
	begin
		if (state == seq_read_wait && acc.done)
			rep.fail_data <= acc.rdata;
	end

endmodule

// ==== psram_test_pkg.sv ====
package psram_test_pkg;

	// ------------------------------
	// widths and test data
	// ------------------------------
	localparam int addr_width = 22;
	localparam int data_width = 8;
	localparam int page_width = 14;
	localparam int offset_width = addr_width - page_width;
	localparam int msg_width = 2;

	localparam logic [data_width-1:0] test_pattern = 8'h9C;

	// ------------------------------
	// ascii codes
	// ------------------------------
	localparam logic [7:0] chr_cr = 8'h0D;
	localparam logic [7:0] chr_lf = 8'h0A;
	localparam logic [7:0] chr_sp = 8'h20;
	localparam logic [7:0] chr_0 = 8'h30;
	localparam logic [7:0] chr_a = 8'h41;
	localparam logic [7:0] chr_e = 8'h45;
	localparam logic [7:0] chr_g = 8'h47;
	localparam logic [7:0] chr_k = 8'h4B;
	localparam logic [7:0] chr_m = 8'h4D;
	localparam logic [7:0] chr_n = 8'h4E;
	localparam logic [7:0] chr_o = 8'h4F;
	localparam logic [7:0] chr_p = 8'h50;
	localparam logic [7:0] chr_r = 8'h52;
	localparam logic [7:0] chr_s = 8'h53;
	localparam logic [7:0] chr_t = 8'h54;

	// ------------------------------
	// messages
	// ------------------------------
	localparam logic [msg_width-1:0] msg_banner = 2'd0;
	localparam logic [msg_width-1:0] msg_ok = 2'd1;
	localparam logic [msg_width-1:0] msg_ram0 = 2'd2;
	localparam logic [msg_width-1:0] msg_ng = 2'd3;

	localparam int banner_len = 12;
	localparam int ok_len = 4;
	localparam int ram0_len = 6;
	// "NG aaaaaa dd\r\n"
	localparam int ng_len = 14;

	localparam logic [8*banner_len-1:0] str_banner = {chr_p, chr_s, chr_r, chr_a, chr_m,
		chr_sp, chr_t, chr_e, chr_s, chr_t, chr_cr, chr_lf};
	localparam logic [8*ok_len-1:0] str_ok = {chr_o, chr_k, chr_cr, chr_lf};
	localparam logic [8*ram0_len-1:0] str_ram0 = {chr_r, chr_a, chr_m, chr_0, chr_cr, chr_lf};

	// ------------------------------
	// state codes
	// ------------------------------
	localparam logic [1:0] port_idle = 2'd0;
	localparam logic [1:0] port_strobe = 2'd1;
	localparam logic [1:0] port_read_wait = 2'd2;

	localparam logic [3:0] seq_boot = 4'd0;
	localparam logic [3:0] seq_banner = 4'd1;
	localparam logic [3:0] seq_init_wait = 4'd2;
	localparam logic [3:0] seq_settle = 4'd3;
	localparam logic [3:0] seq_write = 4'd4;
	localparam logic [3:0] seq_write_wait = 4'd5;
	localparam logic [3:0] seq_read = 4'd6;
	localparam logic [3:0] seq_read_wait = 4'd7;
	localparam logic [3:0] seq_rep_wait = 4'd8;
	localparam logic [3:0] seq_next_phase = 4'd9;
	localparam logic [3:0] seq_done = 4'd10;

	// one address word, seen as page/offset or as hex digits
	typedef union packed {
		struct packed {
			logic [page_width-1:0] page;
			logic [offset_width-1:0] offset;
		} pg;
		struct packed {
			logic [1:0] top;
			logic [4:0][3:0] nib;
		} hex;
	} ram_addr_u;

endpackage

// ==== psram_tester_top.sv ====
`timescale 1ns/1ps

module psram_tester_top #(
	parameter int test_pages = 16384,
	parameter int settle_cycles = 54000000
) (
	input logic clk,
	input logic n_reset,
	input logic initial_busy,
	// ram port
	output logic rd,
	output logic wr,
	output logic [psram_test_pkg::addr_width-1:0] address,
	output logic [psram_test_pkg::data_width-1:0] wdata,
	input logic busy,
	input logic [psram_test_pkg::data_width-1:0] rdata,
	input logic rdata_en,
	// serial send port
	output logic [psram_test_pkg::data_width-1:0] send_data,
	output logic send_req,
	input logic send_busy,
	// status
	output logic test_done,
	output logic test_fail
);

	access_if acc ();
	report_if rep ();

	ram_port_ctrl port_i (
		.clk(clk),
		.n_reset(n_reset),
		.acc(acc.port),
		.rd(rd),
		.wr(wr),
		.address(address),
		.wdata(wdata),
		.busy(busy),
		.rdata_en(rdata_en),
		.rdata(rdata)
	);

	march_sequencer #(
		.test_pages(test_pages),
		.settle_cycles(settle_cycles)
	) seq_i (
		.clk(clk),
		.n_reset(n_reset),
		.initial_busy(initial_busy),
		.acc(acc.seq),
		.rep(rep.seq),
		.test_done(test_done),
		.test_fail(test_fail)
	);

	report_formatter fmt_i (
		.clk(clk),
		.n_reset(n_reset),
		.rep(rep.fmt),
		.send_data(send_data),
		.send_req(send_req),
		.send_busy(send_busy)
	);

endmodule

// ==== ram_port_ctrl.sv ====
`timescale 1ns/1ps

module ram_port_ctrl (
	input logic clk,
	input logic n_reset,
	access_if.port acc,
	output logic rd,
	output logic wr,
	output logic [psram_test_pkg::addr_width-1:0] address,
	output logic [psram_test_pkg::data_width-1:0] wdata,
	input logic busy,
	input logic rdata_en,
	input logic [psram_test_pkg::data_width-1:0] rdata
);
	import psram_test_pkg::*;

	logic [1:0] state;
	logic wr_end;
	logic cmd_any;

	assign cmd_any = acc.cmd_wr | acc.cmd_rd;

	// ------------------------------
	// strobe control
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (!n_reset)
		begin
			state <= port_idle;
			rd <= 1'b0;
			wr <= 1'b0;
			wr_end <= 1'b0;
			acc.done <= 1'b0;
		end
		else
		begin
			// write completes one cycle after the strobe drops
			acc.done <= wr_end;
			wr_end <= 1'b0;
			case (state)
			port_idle:
				if (cmd_any)
				begin
					rd <= acc.cmd_rd;
					wr <= acc.cmd_wr;
					state <= port_strobe;
				end
			port_strobe:
				if (!busy)
				begin
					rd <= 1'b0;
					wr <= 1'b0;
					if (rd)
						state <= port_read_wait;
					else
					begin
						wr_end <= 1'b1;
						state <= port_idle;
					end
				end
			port_read_wait:
				if (rdata_en)
				begin
					acc.done <= 1'b1;
					state <= port_idle;
				end
			default:
				state <= port_idle;
			endcase
		end
	end

	// address, write data and read byte
	always_ff @(posedge clk)
	begin
		if (state == port_idle && cmd_any)
		begin
			address <= acc.address;
			wdata <= acc.wdata;
		end
		if (state == port_read_wait && rdata_en)
			acc.rdata <= rdata;
	end

endmodule

// ==== report_formatter.sv ====
`timescale 1ns/1ps

module report_formatter (
	input logic clk,
	input logic n_reset,
	report_if.fmt rep,
	output logic [psram_test_pkg::data_width-1:0] send_data,
	output logic send_req,
	input logic send_busy
);
	import psram_test_pkg::*;

	logic active;
	logic [3:0] idx;
	logic [3:0] last_idx;
	logic [data_width-1:0] next_char;

	// upper-case hex digit
	function automatic logic [data_width-1:0] hex_char(input logic [3:0] d);
		if (d < 4'd10)
			return chr_0 + data_width'(d);
		else
			return chr_a + data_width'(d) - 8'd10;
	endfunction

	// ------------------------------
	// character select
	// ------------------------------
	always_comb
	begin
		next_char = chr_sp;
		last_idx = 4'(ng_len - 1);
		case (rep.msg)
		msg_banner:
		begin
			next_char = str_banner[8 * (banner_len - 1 - int'(idx)) +: 8];
			last_idx = 4'(banner_len - 1);
		end
		msg_ok:
		begin
			next_char = str_ok[8 * (ok_len - 1 - int'(idx)) +: 8];
			last_idx = 4'(ok_len - 1);
		end
		msg_ram0:
		begin
			next_char = str_ram0[8 * (ram0_len - 1 - int'(idx)) +: 8];
			last_idx = 4'(ram0_len - 1);
		end
		msg_ng:
			case (idx)
			4'd0: next_char = chr_n;
			4'd1: next_char = chr_g;
			// six address digits, the first one only 2 bits wide
			4'd3: next_char = hex_char({2'b00, rep.fail_address.hex.top});
			4'd4: next_char = hex_char(rep.fail_address.hex.nib[4]);
			4'd5: next_char = hex_char(rep.fail_address.hex.nib[3]);
			4'd6: next_char = hex_char(rep.fail_address.hex.nib[2]);
			4'd7: next_char = hex_char(rep.fail_address.hex.nib[1]);
			4'd8: next_char = hex_char(rep.fail_address.hex.nib[0]);
			4'd10: next_char = hex_char(rep.fail_data[7:4]);
			4'd11: next_char = hex_char(rep.fail_data[3:0]);
			4'd12: next_char = chr_cr;
			4'd13: next_char = chr_lf;
			default: next_char = chr_sp;
			endcase
		endcase
	end

	// ------------------------------
	// serial pacing
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (!n_reset)
		begin
			active <= 1'b0;
			idx <= '0;
			send_req <= 1'b0;
			rep.done <= 1'b0;
		end
		else
		begin
			rep.done <= 1'b0;
			if (!active)
			begin
				if (rep.start)
				begin
					active <= 1'b1;
					idx <= '0;
				end
			end
			else if (send_req)
			begin
				if (!send_busy)
				begin
					send_req <= 1'b0;
					if (idx == last_idx)
					begin
						active <= 1'b0;
						rep.done <= 1'b1;
					end
					else
						idx <= idx + 1'b1;
				end
			end
			else
				send_req <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (active && !send_req)
			send_data <= next_char;
	end

endmodule

// ==== report_if.sv ====
`timescale 1ns/1ps

interface report_if;
	import psram_test_pkg::*;

	// request, held until done
	logic start;
	logic [msg_width-1:0] msg;
	ram_addr_u fail_address;
	logic [data_width-1:0] fail_data;

	// last character taken by the serial port
	logic done;

	modport seq (output start, msg, fail_address, fail_data, input done);
	modport fmt (input start, msg, fail_address, fail_data, output done);

endinterface

// ==== sources.f ====
psram_test_pkg.sv
access_if.sv
report_if.sv
ram_port_ctrl.sv
march_sequencer.sv
report_formatter.sv
psram_tester_top.sv
tb_ram_model.sv
tb_psram_tester.sv

// ==== tb_psram_tester.sv ====
`timescale 1ns/1ps

module tb_psram_tester;

	localparam int pages = 2;
	localparam int settle = 20;
	localparam int span = pages * 256;
	localparam int run_limit = 200000;
	localparam int char_limit = 5000;
	localparam int hold_cycles = 50;
	localparam logic [7:0] pattern = 8'h9C;
	localparam string eol = "\015\n";

	logic clk;
	logic n_reset;
	logic initial_busy;
	logic rd;
	logic wr;
	logic [21:0] address;
	logic [7:0] wdata;
	logic busy;
	logic [7:0] rdata;
	logic rdata_en;
	logic [7:0] send_data;
	logic send_req;
	logic send_busy;
	logic test_done;
	logic test_fail;

	logic sink_heavy;
	logic stretch_heavy;
	logic strobe_seen;
	string text;
	string banner_text;
	string ok_text;
	string clean_text;
	int error_count;
	int check_count;

	psram_tester_top #(
		.test_pages(pages),
		.settle_cycles(settle)
	) dut_i (
		.clk(clk),
		.n_reset(n_reset),
		.initial_busy(initial_busy),
		.rd(rd),
		.wr(wr),
		.address(address),
		.wdata(wdata),
		.busy(busy),
		.rdata(rdata),
		.rdata_en(rdata_en),
		.send_data(send_data),
		.send_req(send_req),
		.send_busy(send_busy),
		.test_done(test_done),
		.test_fail(test_fail)
	);

	tb_ram_model ram_i (
		.clk(clk),
		.rd(rd),
		.wr(wr),
		.address(address),
		.wdata(wdata),
		.stretch_heavy(stretch_heavy),
		.busy(busy),
		.rdata(rdata),
		.rdata_en(rdata_en)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ------------------------------
	// serial sink and strobe watch
	// ------------------------------
	always @(posedge clk)
	begin
		if (send_req && !send_busy)
			text = {text, $sformatf("%c", send_data)};
		#2;
		if (sink_heavy)
			send_busy = $urandom_range(3, 0) != 0;
		else
			send_busy = $urandom_range(3, 0) == 0;
	end

	always @(posedge clk)
	begin
		if (rd || wr)
			strobe_seen = 1'b1;
	end

	// CR and LF shown as escapes in error lines
	function automatic string visible(input string s);
		string r;
		r = "";
		for (int i = 0; i < s.len(); i++)
		begin
			if (s[i] == 8'h0D)
				r = {r, "\\r"};
			else if (s[i] == 8'h0A)
				r = {r, "\\n"};
			else
				r = {r, $sformatf("%c", s[i])};
		end
		return r;
	endfunction

	task automatic check_level(input string name, input string what, input logic expected,
		input logic actual);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("ERROR [%s] %s expected %b actual %b", name, what, expected, actual);
		end
	endtask

	task automatic check_text(input string name, input string expected);
		check_count++;
		if (text != expected)
		begin
			error_count++;
			$display("ERROR [%s] text expected \"%s\" actual \"%s\"", name,
				visible(expected), visible(text));
		end
	endtask

	// every tested byte must hold its offset xor the pattern
	task automatic check_memory(input string name);
		logic [21:0] a;
		logic [7:0] expected;
		for (int i = 0; i < span; i++)
		begin
			a = 22'(i);
			expected = 8'(i) ^ pattern;
			check_count++;
			if (!ram_i.written(a))
			begin
				error_count++;
				$display("[%s] location %06h was never written", name, a);
			end
			else if (ram_i.peek(a) != expected)
			begin
				error_count++;
				$display("ERROR [%s] mem[%06h] expected %02h actual %02h", name, a,
					expected, ram_i.peek(a));
			end
		end
	endtask

	// reset for 3 cycles, outputs checked once the first reset edge is taken
	task automatic apply_reset(input string name, input logic hold_init, input logic heavy);
		@(posedge clk);
		#2;
		n_reset = 1'b0;
		initial_busy = hold_init;
		sink_heavy = heavy;
		stretch_heavy = heavy;
		@(posedge clk);
		#1;
		check_level(name, "rd in reset", 1'b0, rd);
		check_level(name, "wr in reset", 1'b0, wr);
		check_level(name, "send_req in reset", 1'b0, send_req);
		repeat (2) @(posedge clk);
		#2;
		ram_i.clear();
		text = "";
		strobe_seen = 1'b0;
		n_reset = 1'b1;
	endtask

	task automatic wait_text_len(input string name, input int len);
		int cycles;
		cycles = 0;
		while (text.len() < len && cycles < char_limit)
		begin
			@(posedge clk);
			cycles++;
		end
		if (text.len() < len)
		begin
			error_count++;
			$display("[%s] timed out waiting for %0d characters, only %0d arrived", name,
				len, text.len());
		end
	endtask

	task automatic wait_done(input string name);
		int cycles;
		cycles = 0;
		while (!test_done && cycles < run_limit)
		begin
			@(posedge clk);
			cycles++;
		end
		if (!test_done)
		begin
			error_count++;
			$display("[%s] timed out waiting for test_done", name);
		end
	endtask

	task automatic check_clean_finish(input string name);
		wait_done(name);
		// end levels and text must hold once the program stops
		repeat (hold_cycles) @(posedge clk);
		#1;
		check_text(name, clean_text);
		check_level(name, "test_done", 1'b1, test_done);
		check_level(name, "test_fail", 1'b0, test_fail);
		check_memory(name);
	endtask

	// ------------------------------
	// directed tests
	// ------------------------------
	task automatic banner_and_init_wait();
		string name;
		name = "banner_wait";
		apply_reset(name, 1'b1, 1'b0);
		wait_text_len(name, banner_text.len());
		// observation window with the memory still initialising
		repeat (300) @(posedge clk);
		check_text(name, banner_text);
		check_level(name, "strobe seen", 1'b0, strobe_seen);
		#2;
		initial_busy = 1'b0;
		wait_text_len(name, banner_text.len() + ok_text.len());
		check_text(name, {banner_text, ok_text});
	endtask

	task automatic clean_run();
		apply_reset("clean_run", 1'b0, 1'b0);
		check_clean_finish("clean_run");
	endtask

	task automatic phase_one_fault();
		string name;
		string ng_line;
		logic [7:0] bad;
		int cycles;
		name = "phase_one_fault";
		bad = (8'h05 ^ pattern) ^ 8'hFF;
		ng_line = $sformatf("ng %06h %02h", 22'h000105, bad);
		ng_line = ng_line.toupper();
		apply_reset(name, 1'b0, 1'b0);
		cycles = 0;
		while (!ram_i.written(22'h000105) && cycles < run_limit)
		begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (!ram_i.written(22'h000105))
		begin
			error_count++;
			$display("[%s] address 000105 was never written", name);
		end
		else
			ram_i.flip_byte(22'h000105);
		wait_done(name);
		repeat (hold_cycles) @(posedge clk);
		#1;
		check_text(name, {banner_text, ok_text, "RAM0", eol, ng_line, eol, ok_text});
		check_level(name, "test_done", 1'b1, test_done);
		check_level(name, "test_fail", 1'b1, test_fail);
		check_memory(name);
	endtask

	task automatic back_pressure_run();
		apply_reset("back_pressure", 1'b0, 1'b1);
		check_clean_finish("back_pressure");
	endtask

	task automatic reset_during_run();
		string name;
		int cycles;
		name = "reset_mid_run";
		// heavy busy stretch keeps the next write strobe up across the reset edge
		apply_reset(name, 1'b0, 1'b1);
		cycles = 0;
		// a quarter into page 0 of phase one
		while (!ram_i.written(22'h000040) && cycles < run_limit)
		begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (!ram_i.written(22'h000040))
		begin
			error_count++;
			$display("[%s] phase one never reached address 000040", name);
		end
		// first cycle of the following write strobe
		cycles = 0;
		while (wr !== 1'b1 && cycles < run_limit)
		begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (wr !== 1'b1)
		begin
			error_count++;
			$display("[%s] no write strobe followed address 000040", name);
		end
		apply_reset(name, 1'b0, 1'b0);
		check_clean_finish(name);
	endtask

	initial
	begin
		void'($urandom(55144));
		n_reset = 1'b0;
		initial_busy = 1'b1;
		send_busy = 1'b0;
		sink_heavy = 1'b0;
		stretch_heavy = 1'b0;
		strobe_seen = 1'b0;
		text = "";
		error_count = 0;
		check_count = 0;
		banner_text = {"PSRAM TEST", eol};
		ok_text = {"OK", eol};
		clean_text = {banner_text, ok_text, "RAM0", eol, ok_text, ok_text};

		banner_and_init_wait();
		clean_run();
		phase_one_fault();
		back_pressure_run();
		reset_during_run();

		$display("summary: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== tb_ram_model.sv ====
`timescale 1ns/1ps

module tb_ram_model (
	input logic clk,
	input logic rd,
	input logic wr,
	input logic [psram_test_pkg::addr_width-1:0] address,
	input logic [psram_test_pkg::data_width-1:0] wdata,
	input logic stretch_heavy,
	output logic busy,
	output logic [psram_test_pkg::data_width-1:0] rdata,
	output logic rdata_en
);
	import psram_test_pkg::*;

	// sparse storage, only written bytes exist
	logic [data_width-1:0] mem [logic [addr_width-1:0]];
	int stretch;
	logic read_pending;
	logic [addr_width-1:0] read_addr;

	initial
	begin
		busy = 1'b0;
		rdata = '0;
		rdata_en = 1'b0;
		stretch = 0;
		read_pending = 1'b0;
		read_addr = '0;
	end

	function automatic int pick_stretch();
		if (stretch_heavy)
			return int'($urandom_range(3, 2));
		return int'($urandom_range(3, 0));
	endfunction

	function automatic logic written(input logic [addr_width-1:0] a);
		return mem.exists(a) ? 1'b1 : 1'b0;
	endfunction

	function automatic logic [data_width-1:0] peek(input logic [addr_width-1:0] a);
		if (mem.exists(a))
			return mem[a];
		return '0;
	endfunction

	// fault hook, inverts every bit of the stored byte
	task automatic flip_byte(input logic [addr_width-1:0] a);
		mem[a] = ~peek(a);
	endtask

	task automatic clear();
		mem.delete();
	endtask

	// ------------------------------
	// access handling
	// ------------------------------
	always @(posedge clk)
	begin
		logic en_next;
		en_next = read_pending;
		read_pending = 1'b0;
		if ((rd || wr) && !busy)
		begin
			if (wr)
				mem[address] = wdata;
			else
			begin
				read_pending = 1'b1;
				read_addr = address;
			end
			// busy level for the next access is chosen now
			stretch = pick_stretch();
		end
		else if ((rd || wr) && stretch > 0)
			stretch = stretch - 1;
		#2;
		busy = stretch > 0;
		rdata_en = en_next;
		if (en_next)
			rdata = peek(read_addr);
	end

endmodule
